//--- axi_xbar.f
src/axi_xbar_pkg.sv
src/axi4_arbiter.sv
src/axi4_mux_w.sv
src/axi4_mux_r.sv
src/axi4_sram_slave.sv
src/axi4_xbar_2x1.sv
bench/axi4_xbar_checker.sv
bench/axi4_xbar_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module axi4_xbar_tb \
   -f axi_xbar.f -o axi4_xbar_sim || { echo "Verilator build failed"; exit 1; }
out=$(./obj_dir/axi4_xbar_sim)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "Simulation PASSED" && exit 0 || exit 1

//--- bench/axi4_xbar_tb.sv
// Testbench for the two-manager AXI crossbar with random bursts and a reference memory.
`timescale 1ns/10ps
`default_nettype none

module axi4_xbar_tb
   import axi_xbar_pkg::*;
();

   localparam int MEM_WORDS  = 256;
   localparam int N_OPS      = 40;
   localparam int MAX_BURSTS = 2 * (16 + 2 * N_OPS);   // Fill bursts plus write/read pairs.

   logic aclk  = 1'b0;
   logic reset = 1'b1;
   aw_t  aw [2]   = '{default: '0};
   ar_t  ar [2]   = '{default: '0};
   w_t   w [2]    = '{default: '0};
   logic aw_v [2] = '{default: 1'b0};
   logic w_v [2]  = '{default: 1'b0};
   logic b_r [2]  = '{default: 1'b0};
   logic ar_v [2] = '{default: 1'b0};
   logic r_r [2]  = '{default: 1'b0};
   logic aw_r [2], w_r [2], b_v [2], ar_r [2], r_v [2];
   b_t   b [2];
   r_t   r [2];
   logic [7:0] model_mem [MEM_WORDS*4];   // Byte-wide reference memory.
   logic start = 1'b0;
   logic done [2] = '{default: 1'b0};
   int   errors = 0;
   int   tests  = 0;

   always #4 aclk = ~aclk;

   axi4_xbar_2x1 #(.MEM_WORDS(MEM_WORDS)) DUT
   (
      .aclk(aclk), .reset(reset),
      .m0_aw_valid(aw_v[0]), .m0_aw_ready(aw_r[0]), .m0_aw(aw[0]),
      .m0_w_valid(w_v[0]), .m0_w_ready(w_r[0]), .m0_w(w[0]),
      .m0_b_valid(b_v[0]), .m0_b_ready(b_r[0]), .m0_b(b[0]),
      .m0_ar_valid(ar_v[0]), .m0_ar_ready(ar_r[0]), .m0_ar(ar[0]),
      .m0_r_valid(r_v[0]), .m0_r_ready(r_r[0]), .m0_r(r[0]),
      .m1_aw_valid(aw_v[1]), .m1_aw_ready(aw_r[1]), .m1_aw(aw[1]),
      .m1_w_valid(w_v[1]), .m1_w_ready(w_r[1]), .m1_w(w[1]),
      .m1_b_valid(b_v[1]), .m1_b_ready(b_r[1]), .m1_b(b[1]),
      .m1_ar_valid(ar_v[1]), .m1_ar_ready(ar_r[1]), .m1_ar(ar[1]),
      .m1_r_valid(r_v[1]), .m1_r_ready(r_r[1]), .m1_r(r[1])
   );

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      assert (exp === act)
      else
      begin
         $display("** Error: %s expected %h actual %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic report_test(input string name, input int errors_before);
      $display("%s: %s", name, (errors == errors_before) ? "ok" : "mismatch");
      tests++;
   endtask

   function automatic logic [31:0] model_word(input int idx);
      return {model_mem[idx*4+3], model_mem[idx*4+2], model_mem[idx*4+1], model_mem[idx*4]};
   endfunction

   // Manager 0 owns words 0 to 127, manager 1 owns 128 up and the range past the end.
   for (genvar g = 0; g < 2; g++)
   begin : mgr
      task automatic write_burst(input int word, input int len, input bit full, input int n);
         string      name;
         logic [3:0] id;
         int         bad;
         resp_e      exp;
         w_t         beat;
         b_t         got;
         name = $sformatf("m%0d write %0d", g, n);
         id   = 4'($urandom);
         bad  = errors;
         exp  = OKAY;
         aw[g] <= '{addr: 16'(word * 4), id: id, len: 8'(len), size: 3'd2, burst: 2'b01,
                    default: '0};
         aw_v[g] <= 1'b1;
         do @(negedge aclk); while (!aw_r[g]);
         @(posedge aclk);
         aw_v[g] <= 1'b0;
         for (int i = 0; i <= len; i++)
         begin
            beat.data = $urandom;
            beat.strb = full ? 4'hf : 4'($urandom);
            beat.last = (i == len);
            w[g]   <= beat;
            w_v[g] <= 1'b1;
            do @(negedge aclk); while (!w_r[g]);
            if (word + i < MEM_WORDS)
            begin
               for (int k = 0; k < 4; k++)
                  if (beat.strb[k])
                     model_mem[(word+i)*4+k] = beat.data[k*8 +: 8];
            end
            else
               exp = SLVERR;   // Out-of-range beats leave memory untouched.
            @(posedge aclk);
         end
         w_v[g] <= 1'b0;
         forever
         begin
            b_r[g] <= 1'($urandom);
            @(negedge aclk);
            if (b_v[g] && b_r[g])
               break;
            @(posedge aclk);
         end
         got = b[g];
         @(posedge aclk);
         b_r[g] <= 1'b0;
         check_value({name, " bid"}, 32'(id), 32'(got.id));
         check_value({name, " bresp"}, 32'(exp), 32'(got.resp));
         report_test(name, bad);
      endtask

      task automatic read_burst(input int word, input int len, input int n);
         string      name;
         logic [3:0] id;
         int         bad;
         int         beats;
         int         idx;
         r_t         got;
         name  = $sformatf("m%0d read %0d", g, n);
         id    = 4'($urandom);
         bad   = errors;
         beats = 0;
         ar[g] <= '{addr: 16'(word * 4), id: id, len: 8'(len), size: 3'd2, burst: 2'b01,
                    default: '0};
         ar_v[g] <= 1'b1;
         do @(negedge aclk); while (!ar_r[g]);
         @(posedge aclk);
         ar_v[g] <= 1'b0;
         while (beats <= len)
         begin
            r_r[g] <= 1'($urandom);
            @(negedge aclk);
            if (r_v[g] && r_r[g])
            begin
               got = r[g];
               idx = word + beats;
               check_value({name, " rdata"}, (idx < MEM_WORDS) ? model_word(idx) : 32'h0,
                           got.data);
               check_value({name, " rresp"}, 32'((idx < MEM_WORDS) ? OKAY : SLVERR),
                           32'(got.resp));
               check_value({name, " rid"}, 32'(id), 32'(got.id));
               check_value({name, " rlast"}, 32'(beats == len), 32'(got.last));
               beats++;
            end
            @(posedge aclk);
         end
         r_r[g] <= 1'b0;
         report_test(name, bad);
      endtask

      initial
      begin
         int n;
         int len;
         int word;
         int mode;
         n = 0;
         wait (start);
         for (int k = 0; k < 16; k++)
         begin
            write_burst(g * 128 + k * 8, 7, 1'b1, n);
            n++;
         end
         for (int k = 0; k < N_OPS; k++)
         begin
            len  = $urandom % 8;
            mode = $urandom % 3;
            word = g * 128 + $urandom % (128 - len);
            if (g == 1 && $urandom % 5 == 0)
               word = 250 + $urandom % 12;   // Burst crosses or starts past the end.
            if (mode == 2)
               read_burst(word, len, n);
            else
            begin
               write_burst(word, len, mode == 0, n);
               read_burst(word, len, n);
            end
            n++;
         end
         done[g] = 1'b1;
      end
   end

   initial
   begin
      void'($urandom(43411));
      repeat (4) @(posedge aclk);
      reset <= 1'b0;
      start = 1'b1;
      wait (done[0] && done[1]);
      repeat (2) @(posedge aclk);
      $display("%0d tests run, %0d errors", tests, errors);
      if (errors == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

   initial
   begin
      repeat (MAX_BURSTS * 40 + 10) @(posedge aclk);
      $display("Watchdog expired before all bursts completed");
      $display("Simulation FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- bench/axi4_xbar_checker.sv
// Assertion checker for grant rules and handshake behavior of the AXI crossbar.
`timescale 1ns/10ps
`default_nettype none

module axi4_xbar_checker
   import axi_xbar_pkg::*;
(
   input wire         aclk,
   input wire         reset,
   input wire grant_t wgrant,
   input wire grant_t rgrant,
   input wire         m0_aw_valid,
   input wire         m1_aw_valid,
   input wire         m0_ar_valid,
   input wire         m1_ar_valid,
   input wire         s_aw_valid,
   input wire         s_w_valid,
   input wire         s_b_valid,
   input wire         s_b_ready,
   input wire         s_ar_valid,
   input wire         s_r_valid,
   input wire         s_r_ready,
   input wire r_t     s_r,
   input wire         m0_b_valid,
   input wire         m1_b_valid,
   input wire         m0_r_valid,
   input wire         m1_r_valid
);

   grant_t last_w;   // Manager that held the write path most recently.
   grant_t last_r;   // Same for the read path.

   always_ff @(posedge aclk)
   begin
      if (reset)
      begin
         last_w <= '0;
         last_r <= '0;
      end
      else
      begin
         if (wgrant != '0)
            last_w <= wgrant;
         if (rgrant != '0)
            last_r <= rgrant;
      end
   end

   grant_onehot: assert property (@(posedge aclk) disable iff (reset)
      $onehot0(wgrant) && $onehot0(rgrant))
      else $error("grant is not one-hot or zero");

   // A held grant may only drop on its closing handshake.
   wgrant_hold: assert property (@(posedge aclk) disable iff (reset)
      (wgrant != '0 && !(s_b_valid && s_b_ready)) |=> wgrant == $past(wgrant))
      else $error("write grant changed outside IDLE");

   rgrant_hold: assert property (@(posedge aclk) disable iff (reset)
      (rgrant != '0 && !(s_r_valid && s_r_ready && s_r.last)) |=> rgrant == $past(rgrant))
      else $error("read grant changed outside IDLE");

   valid_needs_grant: assert property (@(posedge aclk) disable iff (reset)
      ((s_aw_valid || s_w_valid) |-> wgrant != '0) and (s_ar_valid |-> rgrant != '0))
      else $error("valid toward the memory without a grant");

   quiet_after_reset: assert property (@(posedge aclk)
      reset |=> !(m0_b_valid || m1_b_valid || m0_r_valid || m1_r_valid))
      else $error("response valid high right after reset");

   write_alternates: assert property (@(posedge aclk) disable iff (reset)
      (wgrant == '0 && m0_aw_valid && m1_aw_valid && last_w != '0) |=> wgrant != last_w)
      else $error("write grant did not alternate under contention");

   read_alternates: assert property (@(posedge aclk) disable iff (reset)
      (rgrant == '0 && m0_ar_valid && m1_ar_valid && last_r != '0) |=> rgrant != last_r)
      else $error("read grant did not alternate under contention");

endmodule

bind axi4_xbar_2x1 axi4_xbar_checker u_checker (.*);

`default_nettype wire

//--- src/axi4_xbar_2x1.sv
// Two-manager AXI4 crossbar in front of a single on-chip SRAM subordinate.
`timescale 1ns/10ps
`default_nettype none

module axi4_xbar_2x1
   import axi_xbar_pkg::*;
#(
   parameter int MEM_WORDS = 256
)
(
   input  wire       aclk,
   input  wire       reset,
   input  wire       m0_aw_valid,
   output logic      m0_aw_ready,
   input  wire aw_t  m0_aw,
   input  wire       m0_w_valid,
   output logic      m0_w_ready,
   input  wire w_t   m0_w,
   output logic      m0_b_valid,
   input  wire       m0_b_ready,
   output b_t        m0_b,
   input  wire       m0_ar_valid,
   output logic      m0_ar_ready,
   input  wire ar_t  m0_ar,
   output logic      m0_r_valid,
   input  wire       m0_r_ready,
   output r_t        m0_r,
   input  wire       m1_aw_valid,
   output logic      m1_aw_ready,
   input  wire aw_t  m1_aw,
   input  wire       m1_w_valid,
   output logic      m1_w_ready,
   input  wire w_t   m1_w,
   output logic      m1_b_valid,
   input  wire       m1_b_ready,
   output b_t        m1_b,
   input  wire       m1_ar_valid,
   output logic      m1_ar_ready,
   input  wire ar_t  m1_ar,
   output logic      m1_r_valid,
   input  wire       m1_r_ready,
   output r_t        m1_r
);

   grant_t wgrant;
   grant_t rgrant;
   logic   s_aw_valid, s_aw_ready, s_w_valid, s_w_ready, s_b_valid, s_b_ready;
   logic   s_ar_valid, s_ar_ready, s_r_valid, s_r_ready;
   aw_t    s_aw;
   w_t     s_w;
   b_t     s_b;
   ar_t    s_ar;
   r_t     s_r;

   axi4_arbiter u_arbiter (.*, .s_r_last(s_r.last));

   axi4_mux_w u_mux_w (.*);

   axi4_mux_r u_mux_r (.*);

   axi4_sram_slave #(.MEM_WORDS(MEM_WORDS)) u_sram
   (
      .aclk     (aclk),
      .reset    (reset),
      .aw_valid (s_aw_valid),
      .aw_ready (s_aw_ready),
      .aw       (s_aw),
      .w_valid  (s_w_valid),
      .w_ready  (s_w_ready),
      .w        (s_w),
      .b_valid  (s_b_valid),
      .b_ready  (s_b_ready),
      .b        (s_b),
      .ar_valid (s_ar_valid),
      .ar_ready (s_ar_ready),
      .ar       (s_ar),
      .r_valid  (s_r_valid),
      .r_ready  (s_r_ready),
      .r        (s_r)
   );

endmodule

`default_nettype wire

//--- src/axi4_sram_slave.sv
// AXI4 SRAM subordinate with INCR bursts, byte strobes and an address range check.
`timescale 1ns/10ps
`default_nettype none

module axi4_sram_slave
   import axi_xbar_pkg::*;
#(
   parameter int MEM_WORDS = 256
)
(
   input  wire       aclk,
   input  wire       reset,
   input  wire       aw_valid,
   output logic      aw_ready,
   input  wire aw_t  aw,
   input  wire       w_valid,
   output logic      w_ready,
   input  wire w_t   w,
   output logic      b_valid,
   input  wire       b_ready,
   output b_t        b,
   input  wire       ar_valid,
   output logic      ar_ready,
   input  wire ar_t  ar,
   output logic      r_valid,
   input  wire       r_ready,
   output r_t        r
);

   localparam int WORD_W = ADDR_W - ADDR_LSB;
   localparam int IDX_W  = $clog2(MEM_WORDS);

   typedef enum logic [1:0] {WR_IDLE, WR_DATA, WR_RESP} wr_state_e;
   typedef enum logic {RD_IDLE, RD_DATA} rd_state_e;

   logic [DATA_W-1:0] mem [MEM_WORDS];

   wr_state_e         wr_state;
   logic [WORD_W-1:0] wr_addr;   // Word address of the next beat.
   logic [ID_W-1:0]   wr_id;
   resp_e             wr_resp;
   logic              wr_beat;
   logic              wr_in_range;
   rd_state_e         rd_state;
   logic [WORD_W-1:0] rd_addr;
   logic [ID_W-1:0]   rd_id;
   logic [7:0]        rd_left;   // Beats still to send after this one.
   logic              rd_in_range;

   assign wr_beat     = w_valid & w_ready;
   assign wr_in_range = 32'(wr_addr) < MEM_WORDS;
   assign rd_in_range = 32'(rd_addr) < MEM_WORDS;

   always_ff @(posedge aclk)
   begin
      if (reset)
         wr_state <= WR_IDLE;
      else
      begin
         case (wr_state)
            WR_IDLE:
               if (aw_valid)
                  wr_state <= WR_DATA;
            WR_DATA:
               if (wr_beat && w.last)
                  wr_state <= WR_RESP;
            WR_RESP:
               if (b_ready)
                  wr_state <= WR_IDLE;
            default:
               wr_state <= WR_IDLE;
         endcase
      end
   end

   always_ff @(posedge aclk)
   begin
      if (aw_valid && aw_ready)
      begin
         wr_addr <= aw.addr[ADDR_W-1:ADDR_LSB];
         wr_id   <= aw.id;
         wr_resp <= OKAY;
      end
      else if (wr_beat)
      begin
         wr_addr <= wr_addr + WORD_W'(1);
         if (!wr_in_range)
            wr_resp <= SLVERR;   // One bad beat fails the whole burst.
      end
   end

   // Only strobed bytes of in-range beats reach the array.
   always_ff @(posedge aclk)
   begin
      if (wr_beat && wr_in_range)
      begin
         for (int i = 0; i < DATA_BYTES; i++)
         begin
            if (w.strb[i])
               mem[wr_addr[IDX_W-1:0]][i*8 +: 8] <= w.data[i*8 +: 8];
         end
      end
   end

   always_ff @(posedge aclk)
   begin
      if (reset)
         rd_state <= RD_IDLE;
      else
      begin
         case (rd_state)
            RD_IDLE:
               if (ar_valid)
                  rd_state <= RD_DATA;
            RD_DATA:
               if (r_ready && rd_left == '0)
                  rd_state <= RD_IDLE;
         endcase
      end
   end

   always_ff @(posedge aclk)
   begin
      if (ar_valid && ar_ready)
      begin
         rd_addr <= ar.addr[ADDR_W-1:ADDR_LSB];
         rd_id   <= ar.id;
         rd_left <= ar.len;
      end
      else if (r_valid && r_ready)
      begin
         rd_addr <= rd_addr + WORD_W'(1);
         rd_left <= rd_left - 8'd1;
      end
   end

   assign aw_ready = (wr_state == WR_IDLE);
   assign w_ready  = (wr_state == WR_DATA);
   assign b_valid  = (wr_state == WR_RESP);
   assign b        = '{id: wr_id, resp: wr_resp};
   assign ar_ready = (rd_state == RD_IDLE);
   assign r_valid  = (rd_state == RD_DATA);

   // Read beat is held steady by the registered address under back-pressure.
   always_comb
   begin
      r.data = rd_in_range ? mem[rd_addr[IDX_W-1:0]] : '0;
      r.id   = rd_id;
      r.resp = rd_in_range ? OKAY : SLVERR;
      r.last = (rd_left == '0);
   end

endmodule

`default_nettype wire

//--- src/axi4_mux_r.sv
// Read channel multiplexer steering AR and R by the read grant.
`timescale 1ns/10ps
`default_nettype none

module axi4_mux_r
   import axi_xbar_pkg::*;
(
   input  wire grant_t rgrant,
   input  wire         m0_ar_valid,
   output logic        m0_ar_ready,
   input  wire ar_t    m0_ar,
   output logic        m0_r_valid,
   input  wire         m0_r_ready,
   output r_t          m0_r,
   input  wire         m1_ar_valid,
   output logic        m1_ar_ready,
   input  wire ar_t    m1_ar,
   output logic        m1_r_valid,
   input  wire         m1_r_ready,
   output r_t          m1_r,
   output logic        s_ar_valid,
   input  wire         s_ar_ready,
   output ar_t         s_ar,
   input  wire         s_r_valid,
   output logic        s_r_ready,
   input  wire r_t     s_r
);

   assign s_ar_valid = (rgrant[0] & m0_ar_valid) | (rgrant[1] & m1_ar_valid);
   assign s_r_ready  = (rgrant[0] & m0_r_ready) | (rgrant[1] & m1_r_ready);
   assign s_ar       = rgrant[1] ? m1_ar : m0_ar;

   assign m0_ar_ready = rgrant[0] & s_ar_ready;
   assign m0_r_valid  = rgrant[0] & s_r_valid;
   assign m1_ar_ready = rgrant[1] & s_ar_ready;
   assign m1_r_valid  = rgrant[1] & s_r_valid;
   assign m0_r        = s_r;   // Shared read data.
   assign m1_r        = s_r;

endmodule

`default_nettype wire

//--- src/axi4_mux_w.sv
// Write channel multiplexer steering AW, W and B by the write grant.
`timescale 1ns/10ps
`default_nettype none

module axi4_mux_w
   import axi_xbar_pkg::*;
(
   input  wire grant_t wgrant,
   input  wire         m0_aw_valid,
   output logic        m0_aw_ready,
   input  wire aw_t    m0_aw,
   input  wire         m0_w_valid,
   output logic        m0_w_ready,
   input  wire w_t     m0_w,
   output logic        m0_b_valid,
   input  wire         m0_b_ready,
   output b_t          m0_b,
   input  wire         m1_aw_valid,
   output logic        m1_aw_ready,
   input  wire aw_t    m1_aw,
   input  wire         m1_w_valid,
   output logic        m1_w_ready,
   input  wire w_t     m1_w,
   output logic        m1_b_valid,
   input  wire         m1_b_ready,
   output b_t          m1_b,
   output logic        s_aw_valid,
   input  wire         s_aw_ready,
   output aw_t         s_aw,
   output logic        s_w_valid,
   input  wire         s_w_ready,
   output w_t          s_w,
   input  wire         s_b_valid,
   output logic        s_b_ready,
   input  wire b_t     s_b
);

   // Without a grant every valid toward the memory stays low.
   assign s_aw_valid = (wgrant[0] & m0_aw_valid) | (wgrant[1] & m1_aw_valid);
   assign s_w_valid  = (wgrant[0] & m0_w_valid) | (wgrant[1] & m1_w_valid);
   assign s_b_ready  = (wgrant[0] & m0_b_ready) | (wgrant[1] & m1_b_ready);
   assign s_aw       = wgrant[1] ? m1_aw : m0_aw;
   assign s_w        = wgrant[1] ? m1_w : m0_w;

   assign m0_aw_ready = wgrant[0] & s_aw_ready;
   assign m0_w_ready  = wgrant[0] & s_w_ready;
   assign m0_b_valid  = wgrant[0] & s_b_valid;
   assign m1_aw_ready = wgrant[1] & s_aw_ready;
   assign m1_w_ready  = wgrant[1] & s_w_ready;
   assign m1_b_valid  = wgrant[1] & s_b_valid;
   assign m0_b        = s_b;   // Payload goes to both, valid picks the owner.
   assign m1_b        = s_b;

endmodule

`default_nettype wire

//--- src/axi4_arbiter.sv
// Round-robin arbiter that grants the write and the read path independently.
`timescale 1ns/10ps
`default_nettype none

module axi4_arbiter
   import axi_xbar_pkg::*;
(
   input  wire    aclk,
   input  wire    reset,
   input  wire    m0_aw_valid,
   input  wire    m1_aw_valid,
   input  wire    m0_ar_valid,
   input  wire    m1_ar_valid,
   input  wire    s_b_valid,
   input  wire    s_b_ready,
   input  wire    s_r_valid,
   input  wire    s_r_ready,
   input  wire    s_r_last,
   output grant_t wgrant,
   output grant_t rgrant
);

   logic [1:0] req  [2];   // Index 0 is the write path, 1 the read path.
   logic       done [2];

   assign req[0]  = {m1_aw_valid, m0_aw_valid};
   assign req[1]  = {m1_ar_valid, m0_ar_valid};
   assign done[0] = s_b_valid & s_b_ready;               // Write ends on B.
   assign done[1] = s_r_valid & s_r_ready & s_r_last;    // Read ends on last R beat.

   genvar p;
   generate
      for (p = 0; p < 2; p++)
      begin : path
         arb_state_e state;
         grant_t     grant;
         grant_t     pick;
         logic       last_m1;   // Manager 1 was served last.

         // On contention the manager not served last wins.
         always_comb
         begin
            if (req[p] == 2'b11)
               pick = last_m1 ? 2'b01 : 2'b10;
            else
               pick = req[p];
         end

         always_ff @(posedge aclk)
         begin
            if (reset)
            begin
               state   <= IDLE;
               grant   <= '0;
               last_m1 <= 1'b1;   // Manager 0 goes first.
            end
            else
            begin
               case (state)
                  IDLE:
                     if (pick != '0)
                     begin
                        state   <= BUSY;
                        grant   <= pick;
                        last_m1 <= pick[1];
                     end
                  BUSY:
                     if (done[p])
                     begin
                        state <= IDLE;
                        grant <= '0;
                     end
                  default:
                     state <= IDLE;
               endcase
            end
         end
      end
   endgenerate

   assign wgrant = path[0].grant;
   assign rgrant = path[1].grant;

endmodule

`default_nettype wire

//--- src/axi_xbar_pkg.sv
// AXI crossbar package with bus widths, channel structs and the shared enums.
`default_nettype none

package axi_xbar_pkg;

   localparam int ADDR_W     = 16;
   localparam int ID_W       = 4;
   localparam int DATA_BYTES = 4;
   localparam int DATA_W     = DATA_BYTES * 8;
   localparam int ADDR_LSB   = $clog2(DATA_BYTES);   // Byte offset bits within a beat.

   typedef enum logic [1:0]
   {
      OKAY   = 2'b00,
      EXOKAY = 2'b01,
      SLVERR = 2'b10,
      DECERR = 2'b11
   } resp_e;

   typedef enum logic {IDLE, BUSY} arb_state_e;

   // One-hot grant with bit 0 selecting manager 0.
   typedef logic [1:0] grant_t;

   typedef struct packed
   {
      logic [ADDR_W-1:0] addr;
      logic [ID_W-1:0]   id;
      logic [7:0]        len;      // Beats minus one.
      logic [2:0]        size;
      logic [1:0]        burst;    // Always handled as INCR.
      logic              lock;
      logic [3:0]        cache;
      logic [2:0]        prot;
      logic [3:0]        qos;
      logic [3:0]        region;
   } aw_t;

   // Read address carries exactly the write address fields.
   typedef aw_t ar_t;

   typedef struct packed
   {
      logic [DATA_W-1:0]     data;
      logic [DATA_BYTES-1:0] strb;
      logic                  last;
   } w_t;

   typedef struct packed
   {
      logic [ID_W-1:0] id;
      resp_e           resp;
   } b_t;

   typedef struct packed
   {
      logic [DATA_W-1:0] data;
      logic [ID_W-1:0]   id;
      resp_e             resp;
      logic              last;
   } r_t;

endpackage

`default_nettype wire
